/* files.f */
+incdir+source
source/spad_dma_pkg.sv
source/rr_arbiter.sv
source/line_fifo.sv
source/spad_bank.sv
source/rd_dma.sv
source/width_conv.sv
source/spad_dma_top.sv
tests/tb_spad_dma.sv

/* run_sim.sh */
#!/bin/sh
# Build the spad_dma testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_spad_dma \
  -f files.f -o tb_spad_dma
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_spad_dma > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

/* tests/tb_spad_dma.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module tb_spad_dma
  import spad_dma_pkg::*;
();

  localparam int LINE_BYTES      = `SPAD_DATA_WIDTH / 8;
  localparam int LINES           = 2 ** $bits(line_idx_t);
  localparam int SPAD_BYTES      = LINES * LINE_BYTES;
  localparam int CYCLES_PER_BYTE = 40;
  localparam int MARGIN_CYCLES   = 3000;

  // Single reads rotate over the accelerators
  localparam int SINGLE_N = 8;
  localparam int SINGLE_ADDR [SINGLE_N] = '{0, 8, 13, 5, 66, 129, 402, 1021};
  localparam int SINGLE_LEN  [SINGLE_N] = '{4, 16, 1, 7, 33, 2, 255, 3};
  localparam int MULTI_ADDR [`ACCEL_COUNT] = '{100, 301, 555, 770};
  localparam int MULTI_LEN  [`ACCEL_COUNT] = '{50, 37, 64, 21};
  localparam int HOLD_ADDR  [`ACCEL_COUNT] = '{600, 10, 211, 890};
  localparam int HOLD_LEN   [`ACCEL_COUNT] = '{40, 25, 30, 19};
  localparam int STOP_ID      = 2;
  localparam int STOP_ADDR    = 700;
  localparam int STOP_LEN     = 200;
  localparam int STOP_AFTER   = 20;
  localparam int RESTART_ADDR = 37;
  localparam int RESTART_LEN  = 18;

  logic                              clk = 1'b0;
  logic                              rst;
  logic                              desc_valid;
  accel_id_t                         desc_accel_id;
  spad_addr_t                        desc_addr;
  logic [`LEN_WIDTH-1:0]             desc_len;
  logic [`ACCEL_COUNT-1:0]           accel_stop;
  logic [`ACCEL_COUNT-1:0]           accel_busy;
  logic                              wr_en;
  line_idx_t                         wr_line;
  logic [`SPAD_DATA_WIDTH-1:0]       wr_data;
  logic [`ACCEL_COUNT*`OUT_WIDTH-1:0] accel_data;
  logic [`ACCEL_COUNT-1:0]           accel_last;
  logic [`ACCEL_COUNT-1:0]           accel_valid;
  logic [`ACCEL_COUNT-1:0]           accel_ready;

  // Byte copy of the scratchpad and the bytes each accelerator still owes
  logic [7:0]              spad_model [SPAD_BYTES];
  logic [7:0]              exp_q [`ACCEL_COUNT][$];
  int                      rx_count [`ACCEL_COUNT];
  logic [31:0]             rng = 32'h1bde98e7;
  bit                      stall_mode = 1'b0;
  logic [`ACCEL_COUNT-1:0] ready_hold = '0;

  spad_dma_top spad_dma_top_inst (
    .clk           (clk),
    .rst           (rst),
    .desc_valid    (desc_valid),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .accel_stop    (accel_stop),
    .accel_busy    (accel_busy),
    .wr_en         (wr_en),
    .wr_line       (wr_line),
    .wr_data       (wr_data),
    .accel_data    (accel_data),
    .accel_last    (accel_last),
    .accel_valid   (accel_valid),
    .accel_ready   (accel_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int total_bytes();
    int sum;
    sum = STOP_LEN + RESTART_LEN;
    for (int k = 0; k < SINGLE_N; k++)
      sum += SINGLE_LEN[k];
    for (int k = 0; k < `ACCEL_COUNT; k++)
      sum += MULTI_LEN[k] + HOLD_LEN[k];
    return sum;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  // One clock step that also redraws accel_ready
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    rng = xorshift32(rng);
    r = stall_mode ? rng : '1;
    accel_ready <= (r[`ACCEL_COUNT-1:0] | r[2*`ACCEL_COUNT-1:`ACCEL_COUNT]) & ~ready_hold;
  endtask

  task automatic load_scratchpad();
    logic [31:0] word;
    for (int line = 0; line < LINES; line++) begin
      tick();
      rng = xorshift32(rng);
      word = rng;
      wr_en   <= 1'b1;
      wr_line <= line_idx_t'(line);
      wr_data <= word;
      for (int b = 0; b < LINE_BYTES; b++)
        spad_model[line*LINE_BYTES + b] = word[8*b +: 8];
    end
    tick();
    wr_en <= 1'b0;
  endtask

  task automatic send_desc(input int id, input int addr, input int len);
    for (int k = 0; k < len; k++)
      exp_q[id].push_back(spad_model[(addr + k) % SPAD_BYTES]);
    tick();
    desc_valid     <= 1'b1;
    desc_accel_id  <= accel_id_t'(id);
    desc_addr.flat <= `SPAD_ADDR_WIDTH'(addr);
    desc_len       <= `LEN_WIDTH'(len);
    tick();
    desc_valid <= 1'b0;
  endtask

  function automatic bit streams_pending(input logic [`ACCEL_COUNT-1:0] mask);
    bit pending;
    pending = 1'b0;
    for (int i = 0; i < `ACCEL_COUNT; i++)
      if (mask[i] && (exp_q[i].size() != 0 || accel_busy[i]))
        pending = 1'b1;
    return pending;
  endfunction

  task automatic wait_streams(input logic [`ACCEL_COUNT-1:0] mask);
    int cycles;
    int limit;
    bit pending;
    limit = MARGIN_CYCLES;
    for (int i = 0; i < `ACCEL_COUNT; i++)
      limit += CYCLES_PER_BYTE * exp_q[i].size();
    cycles = 0;
    pending = 1'b1;
    while (pending && cycles < limit) begin
      tick();
      @(negedge clk);
      cycles++;
      pending = streams_pending(mask);
    end
    if (pending)
      report_failure($sformatf("Streams of accelerator mask 0x%0h did not finish in %0d cycles",
                               mask, limit));
  endtask

  // Collectors sample the byte streams at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `ACCEL_COUNT; i++) begin
        if (accel_valid[i] && accel_ready[i]) begin
          if (exp_q[i].size() == 0) begin
            report_failure($sformatf("Accelerator %0d received a byte it did not ask for", i));
          end else begin
            check_value($sformatf("accel_data[%0d]", i),
                        32'(accel_data[i*`OUT_WIDTH +: `OUT_WIDTH]), 32'(exp_q[i][0]));
            check_value($sformatf("accel_last[%0d]", i),
                        32'(accel_last[i]), 32'(exp_q[i].size() == 1));
            void'(exp_q[i].pop_front());
            rx_count[i]++;
          end
        end
      end
    end
  end

  task automatic verify_idle_after_reset();
    @(negedge clk);
    check_value("accel_busy", 32'(accel_busy), 32'h0);
    check_value("accel_valid", 32'(accel_valid), 32'h0);
  endtask

  task automatic aligned_unaligned_reads();
    int id;
    for (int k = 0; k < SINGLE_N; k++) begin
      id = k % `ACCEL_COUNT;
      send_desc(id, SINGLE_ADDR[k], SINGLE_LEN[k]);
      @(negedge clk);
      check_value($sformatf("accel_busy[%0d]", id), 32'(accel_busy[id]), 32'h1);
      wait_streams(`ACCEL_COUNT'(1) << id);
      @(negedge clk);
      check_value("accel_busy", 32'(accel_busy), 32'h0);
      check_value("accel_valid", 32'(accel_valid), 32'h0);
    end
  endtask

  task automatic concurrent_stalled_reads();
    stall_mode = 1'b1;
    for (int k = 0; k < `ACCEL_COUNT; k++)
      send_desc(k, MULTI_ADDR[k], MULTI_LEN[k]);
    wait_streams('1);
    stall_mode = 1'b0;
  endtask

  task automatic stop_and_restart();
    int target;
    int cycles;
    send_desc(STOP_ID, STOP_ADDR, STOP_LEN);
    target = rx_count[STOP_ID] + STOP_AFTER;
    cycles = 0;
    while (rx_count[STOP_ID] < target && cycles < MARGIN_CYCLES) begin
      tick();
      cycles++;
    end
    if (rx_count[STOP_ID] < target)
      report_failure("Long transfer produced too few bytes before the stop");
    tick();
    accel_stop <= `ACCEL_COUNT'(1) << STOP_ID;
    tick();
    accel_stop <= '0;
    // Bytes already in the output register may still drain
    repeat (3) tick();
    exp_q[STOP_ID].delete();
    repeat (30) begin
      tick();
      @(negedge clk);
      check_value("accel_valid[2]", 32'(accel_valid[STOP_ID]), 32'h0);
      check_value("accel_busy[2]", 32'(accel_busy[STOP_ID]), 32'h0);
    end
    send_desc(STOP_ID, RESTART_ADDR, RESTART_LEN);
    wait_streams(`ACCEL_COUNT'(1) << STOP_ID);
  endtask

  task automatic blocked_accel_isolation();
    ready_hold = `ACCEL_COUNT'(1);
    for (int k = 0; k < `ACCEL_COUNT; k++)
      send_desc(k, HOLD_ADDR[k], HOLD_LEN[k]);
    wait_streams(~`ACCEL_COUNT'(1));
    check_value("accel_busy[0]", 32'(accel_busy[0]), 32'h1);
    check_value("accel_valid[0]", 32'(accel_valid[0]), 32'h1);
    ready_hold = '0;
    wait_streams(`ACCEL_COUNT'(1));
  endtask

  // Watchdog sized from the byte count of all tests
  initial begin
    int limit;
    limit = total_bytes() * CYCLES_PER_BYTE + LINES + MARGIN_CYCLES;
    repeat (limit) @(posedge clk);
    report_failure($sformatf("Timeout: the tests did not finish within %0d cycles", limit));
  end

  initial begin
    rst           <= 1'b1;
    desc_valid    <= 1'b0;
    desc_accel_id <= '0;
    desc_addr     <= '0;
    desc_len      <= '0;
    accel_stop    <= '0;
    wr_en         <= 1'b0;
    wr_line       <= '0;
    wr_data       <= '0;
    accel_ready   <= '1;
    repeat (5) tick();
    rst <= 1'b0;
    verify_idle_after_reset();
    load_scratchpad();
    aligned_unaligned_reads();
    concurrent_stalled_reads();
    stop_and_restart();
    blocked_accel_isolation();
    $display("Everything OK");
    $finish;
  end

endmodule

/* source/spad_dma_top.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module spad_dma_top
  import spad_dma_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 desc_valid,
  input  accel_id_t                            desc_accel_id,
  input  spad_addr_t                           desc_addr,
  input  logic [`LEN_WIDTH-1:0]                desc_len,
  input  logic [`ACCEL_COUNT-1:0]              accel_stop,
  output logic [`ACCEL_COUNT-1:0]              accel_busy,
  input  logic                                 wr_en,
  input  line_idx_t                            wr_line,
  input  logic [`SPAD_DATA_WIDTH-1:0]          wr_data,
  output logic [`ACCEL_COUNT*`OUT_WIDTH-1:0]   accel_data,
  output logic [`ACCEL_COUNT-1:0]              accel_last,
  output logic [`ACCEL_COUNT-1:0]              accel_valid,
  input  logic [`ACCEL_COUNT-1:0]              accel_ready
);

  localparam int DW    = `SPAD_DATA_WIDTH;
  localparam int OFS_W = $bits(byte_ofs_t);

  logic          b0_rd_en, b1_rd_en;
  bank_addr_t    b0_rd_addr, b1_rd_addr;
  logic [DW-1:0] b0_rd_data, b1_rd_data;

  logic [`ACCEL_COUNT*DW-1:0]    line_data;
  logic [`ACCEL_COUNT*OFS_W-1:0] line_ptr;
  logic [`ACCEL_COUNT-1:0]       line_last, line_valid, line_ready;

  // Even lines in bank 0, odd lines in bank 1
  spad_bank bank0 (
    .clk     (clk),
    .wr_en   (wr_en && !wr_line[0]),
    .wr_addr (wr_line[$bits(line_idx_t)-1:1]),
    .wr_data (wr_data),
    .rd_en   (b0_rd_en),
    .rd_addr (b0_rd_addr),
    .rd_data (b0_rd_data)
  );

  spad_bank bank1 (
    .clk     (clk),
    .wr_en   (wr_en && wr_line[0]),
    .wr_addr (wr_line[$bits(line_idx_t)-1:1]),
    .wr_data (wr_data),
    .rd_en   (b1_rd_en),
    .rd_addr (b1_rd_addr),
    .rd_data (b1_rd_data)
  );

  rd_dma engine (
    .clk           (clk),
    .rst           (rst),
    .desc_valid    (desc_valid),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .accel_stop    (accel_stop),
    .accel_busy    (accel_busy),
    .b0_rd_en      (b0_rd_en),
    .b0_rd_addr    (b0_rd_addr),
    .b0_rd_data    (b0_rd_data),
    .b1_rd_en      (b1_rd_en),
    .b1_rd_addr    (b1_rd_addr),
    .b1_rd_data    (b1_rd_data),
    .line_data     (line_data),
    .line_ptr      (line_ptr),
    .line_last     (line_last),
    .line_valid    (line_valid),
    .line_ready    (line_ready)
  );

  for (genvar i = 0; i < `ACCEL_COUNT; i++) begin : g_conv
    width_conv conv (
      .clk       (clk),
      .rst       (rst),
      .in_data   (line_data[i*DW +: DW]),
      .in_ptr    (line_ptr[i*OFS_W +: OFS_W]),
      .in_last   (line_last[i]),
      .in_valid  (line_valid[i]),
      .in_ready  (line_ready[i]),
      .out_data  (accel_data[i*`OUT_WIDTH +: `OUT_WIDTH]),
      .out_last  (accel_last[i]),
      .out_valid (accel_valid[i]),
      .out_ready (accel_ready[i])
    );
  end

endmodule

/* source/width_conv.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module width_conv
  import spad_dma_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`SPAD_DATA_WIDTH-1:0] in_data,
  input  byte_ofs_t                   in_ptr,
  input  logic                        in_last,
  input  logic                        in_valid,
  output logic                        in_ready,
  output logic [`OUT_WIDTH-1:0]       out_data,
  output logic                        out_last,
  output logic                        out_valid,
  input  logic                        out_ready
);

  byte_ofs_t ptr;
  logic      advance;
  logic      last_chunk;
  logic      held;

  // Output register is free when empty or being taken
  assign advance    = !out_valid || out_ready;
  assign last_chunk = (ptr == in_ptr);
  assign in_ready   = advance && last_chunk;

  always_ff @(posedge clk) begin
    if (advance)
      out_data <= in_data[ptr*`OUT_WIDTH +: `OUT_WIDTH];
    if (rst) begin
      ptr       <= '0;
      held      <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      // Line offered but not taken last cycle
      held <= in_valid && !in_ready;
      if (!in_valid)
        ptr <= '0;
      else if (advance)
        ptr <= last_chunk ? '0 : ptr + 1'b1;
      // Line vanished from the FIFO, the stream was stopped
      if (held && !in_valid) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end else if (advance) begin
        out_valid <= in_valid;
        out_last  <= in_valid && in_last && last_chunk;
      end
    end
  end

endmodule

/* source/rd_dma.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module rd_dma
  import spad_dma_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         desc_valid,
  input  accel_id_t                                    desc_accel_id,
  input  spad_addr_t                                   desc_addr,
  input  logic [`LEN_WIDTH-1:0]                        desc_len,
  input  logic [`ACCEL_COUNT-1:0]                      accel_stop,
  output logic [`ACCEL_COUNT-1:0]                      accel_busy,
  output logic                                         b0_rd_en,
  output bank_addr_t                                   b0_rd_addr,
  input  logic [`SPAD_DATA_WIDTH-1:0]                  b0_rd_data,
  output logic                                         b1_rd_en,
  output bank_addr_t                                   b1_rd_addr,
  input  logic [`SPAD_DATA_WIDTH-1:0]                  b1_rd_data,
  output logic [`ACCEL_COUNT*`SPAD_DATA_WIDTH-1:0]     line_data,
  output logic [`ACCEL_COUNT*$bits(byte_ofs_t)-1:0]    line_ptr,
  output logic [`ACCEL_COUNT-1:0]                      line_last,
  output logic [`ACCEL_COUNT-1:0]                      line_valid,
  input  logic [`ACCEL_COUNT-1:0]                      line_ready
);

  localparam int DW    = `SPAD_DATA_WIDTH;
  localparam int OFS_W = $bits(byte_ofs_t);

  logic [`ACCEL_COUNT-1:0] stop_latch, stop_hold, desc_1hot, line_done;
  logic [`LEN_WIDTH-1:0]   len_m1;

  // Descriptor registered one cycle after the strobe
  logic      req_v;
  accel_id_t req_dest;
  line_idx_t req_line;
  byte_ofs_t req_ofs, req_final;
  line_cnt_t req_rem;

  assign stop_hold = accel_stop | stop_latch;
  assign desc_1hot = desc_valid ? (`ACCEL_COUNT'(1) << desc_accel_id) : '0;
  assign line_done = line_valid & line_ready & line_last;
  assign len_m1    = desc_len - `LEN_WIDTH'(1);

  always_ff @(posedge clk) begin
    req_dest  <= desc_accel_id;
    req_line  <= desc_addr.part.line;
    req_ofs   <= desc_addr.part.ofs;
    req_rem   <= len_m1[`LEN_WIDTH-1:OFS_W];
    req_final <= len_m1[OFS_W-1:0];
    if (rst) begin
      req_v      <= 1'b0;
      stop_latch <= '0;
      accel_busy <= '0;
    end else begin
      req_v      <= desc_valid;
      stop_latch <= (stop_latch | accel_stop) & ~desc_1hot;
      accel_busy <= (accel_busy & ~stop_hold & ~line_done) | desc_1hot;
    end
  end

  // Next line and lines left of each active transfer
  line_idx_t act_line  [`ACCEL_COUNT];
  line_cnt_t act_rem   [`ACCEL_COUNT];
  byte_ofs_t act_final [`ACCEL_COUNT];
  byte_ofs_t act_ofs   [`ACCEL_COUNT];
  logic [`ACCEL_COUNT-1:0] act_v, credit_ok, arb_req, arb_grant, issue;
  logic      arb_v;
  accel_id_t arb_id;

  // A fresh descriptor takes the read slot, so the arbiter sits out
  assign arb_req = (req_v ? '0 : act_v) & credit_ok & ~stop_hold;
  assign issue   = (req_v ? (`ACCEL_COUNT'(1) << req_dest) : '0) | arb_grant;

  rr_arbiter act_arb (
    .clk         (clk),
    .rst         (rst),
    .request     (arb_req),
    .grant       (arb_grant),
    .grant_valid (arb_v),
    .grant_id    (arb_id)
  );

  // Issue source for this cycle
  line_idx_t iss_line, iss_line_n;
  line_cnt_t iss_rem;
  byte_ofs_t iss_ofs, iss_final;
  accel_id_t iss_dest;

  assign iss_line   = req_v ? req_line  : act_line[arb_id];
  assign iss_rem    = req_v ? req_rem   : act_rem[arb_id];
  assign iss_ofs    = req_v ? req_ofs   : act_ofs[arb_id];
  assign iss_final  = req_v ? req_final : act_final[arb_id];
  assign iss_dest   = req_v ? req_dest  : arb_id;
  assign iss_line_n = iss_line + line_idx_t'(1);

  always_ff @(posedge clk) begin
    if (req_v || arb_v) begin
      act_line[iss_dest] <= iss_line_n;
      act_rem[iss_dest]  <= iss_rem - line_cnt_t'(1);
    end
    if (req_v) begin
      act_final[req_dest] <= req_final;
      act_ofs[req_dest]   <= req_ofs;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      act_v <= '0;
    else if ((req_v || arb_v) && iss_rem == '0)
      act_v <= act_v & ~issue & ~stop_hold;
    else
      act_v <= (act_v | issue) & ~stop_hold;
  end

  // Read pipeline where stage 0 drives the banks and stage 3 writes a FIFO
  logic [3:0] p_en, p_last;
  logic [2:0] p_bank;
  accel_id_t  p_dest [4];
  byte_ofs_t  p_ptr  [4];
  byte_ofs_t  p_ofs  [3];
  logic [DW-1:0]   b0_q, b1_q, aligned;
  logic [2*DW-1:0] shifted;

  always_ff @(posedge clk) begin
    p_dest[0]  <= iss_dest;
    p_ptr[0]   <= (iss_rem == '0) ? iss_final : '1;
    p_last[0]  <= (iss_rem == '0);
    p_ofs[0]   <= iss_ofs;
    p_bank[0]  <= iss_line[0];
    b0_rd_addr <= iss_line_n[$bits(line_idx_t)-1:1];
    b1_rd_addr <= iss_line[$bits(line_idx_t)-1:1];
    for (int k = 1; k < 4; k++) begin
      p_dest[k] <= p_dest[k-1];
      p_ptr[k]  <= p_ptr[k-1];
      p_last[k] <= p_last[k-1];
    end
    for (int k = 1; k < 3; k++) begin
      p_ofs[k]  <= p_ofs[k-1];
      p_bank[k] <= p_bank[k-1];
    end
    b0_q    <= b0_rd_data;
    b1_q    <= b1_rd_data;
    aligned <= shifted[DW-1:0];
    if (rst)
      p_en <= '0;
    else
      p_en <= {p_en[2:0], req_v || arb_v};
  end

  assign b0_rd_en = p_en[0];
  assign b1_rd_en = p_en[0];

  // Odd start line sits in bank 1, so bank 0 holds the upper half
  assign shifted = (p_bank[2] ? {b0_q, b1_q} : {b1_q, b0_q}) >> {p_ofs[2], 3'b000};

  logic [`ACCEL_COUNT-1:0] fifo_wr;

  for (genvar i = 0; i < `ACCEL_COUNT; i++) begin : g_accel
    logic [$clog2(`FIFO_LINES):0] credits;
    logic                         pop;

    assign pop          = line_valid[i] && line_ready[i];
    assign credit_ok[i] = (credits < ($clog2(`FIFO_LINES)+1)'(`FIFO_LINES));
    assign fifo_wr[i]   = p_en[3] && (p_dest[3] == accel_id_t'(i));

    // Lines in flight plus lines stored
    always_ff @(posedge clk) begin
      if (rst || stop_hold[i])
        credits <= '0;
      else if (issue[i] && !pop)
        credits <= credits + 1'b1;
      else if (pop && !issue[i])
        credits <= credits - 1'b1;
    end

    line_fifo #(
      .WIDTH (1 + OFS_W + DW)
    ) fifo (
      .clk      (clk),
      .rst      (rst),
      .clear    (stop_hold[i]),
      .wr_valid (fifo_wr[i]),
      .wr_data  ({p_last[3], p_ptr[3], aligned}),
      .rd_valid (line_valid[i]),
      .rd_data  ({line_last[i], line_ptr[i*OFS_W +: OFS_W], line_data[i*DW +: DW]}),
      .rd_ready (line_ready[i])
    );
  end

  desc_to_idle_accel: assert property (@(posedge clk) disable iff (rst)
    desc_valid |-> !accel_busy[desc_accel_id])
    else $error("descriptor sent to a busy accelerator");

  // Descriptor and arbiter share one read slot, one FIFO write per issued line
  single_line_issue: assert property (@(posedge clk) disable iff (rst)
    $onehot0(issue))
    else $error("more than one line issued in a cycle");

endmodule

/* source/spad_bank.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module spad_bank
  import spad_dma_pkg::*;
(
  input  logic                        clk,
  input  logic                        wr_en,
  input  bank_addr_t                  wr_addr,
  input  logic [`SPAD_DATA_WIDTH-1:0] wr_data,
  input  logic                        rd_en,
  input  bank_addr_t                  rd_addr,
  output logic [`SPAD_DATA_WIDTH-1:0] rd_data
);

  logic [`SPAD_DATA_WIDTH-1:0] mem [2**$bits(bank_addr_t)];

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

/* source/line_fifo.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module line_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,
  input  logic             wr_valid,
  input  logic [WIDTH-1:0] wr_data,
  output logic             rd_valid,
  output logic [WIDTH-1:0] rd_data,
  input  logic             rd_ready
);

  localparam int PTR_W = $clog2(`FIFO_LINES);

  logic [WIDTH-1:0] mem [`FIFO_LINES];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             push;
  logic             pop;

  assign full     = (count == (PTR_W+1)'(`FIFO_LINES));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign push     = wr_valid && !full;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= wr_data;
  end

  // Clear drops everything stored, same as reset
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  // Upstream credits keep writes away from a full FIFO
  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    wr_valid && !clear |-> !full)
    else $error("line_fifo written while full");

endmodule

/* source/rr_arbiter.sv */
`timescale 1ns/1ps
`include "spad_dma_settings.svh"

module rr_arbiter
  import spad_dma_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`ACCEL_COUNT-1:0] request,
  output logic [`ACCEL_COUNT-1:0] grant,
  output logic                    grant_valid,
  output accel_id_t               grant_id
);

  // Requester that won most recently, search starts just after it
  accel_id_t last_id;

  always_comb begin
    accel_id_t idx;
    grant_valid = 1'b0;
    grant_id    = last_id;
    grant       = '0;
    for (int k = 1; k <= `ACCEL_COUNT; k++) begin
      idx = accel_id_t'(last_id + k);
      if (!grant_valid && request[idx]) begin
        grant_valid = 1'b1;
        grant_id    = idx;
      end
    end
    if (grant_valid)
      grant[grant_id] = 1'b1;
  end

  // Start so that accelerator 0 has top priority out of reset
  always_ff @(posedge clk) begin
    if (rst)
      last_id <= accel_id_t'(`ACCEL_COUNT - 1);
    else if (grant_valid)
      last_id <= grant_id;
  end

endmodule

/* source/spad_dma_pkg.sv */
`include "spad_dma_settings.svh"

package spad_dma_pkg;

  // Byte position inside one scratchpad line
  typedef logic [$clog2(`SPAD_DATA_WIDTH/8)-1:0] byte_ofs_t;

  typedef logic [`SPAD_ADDR_WIDTH-$bits(byte_ofs_t)-1:0] line_idx_t;

  // Line index without its bank select bit
  typedef logic [$bits(line_idx_t)-2:0] bank_addr_t;

  typedef logic [$clog2(`ACCEL_COUNT)-1:0] accel_id_t;

  // Remaining lines of a transfer, kept as count minus one
  typedef logic [`LEN_WIDTH-$bits(byte_ofs_t)-1:0] line_cnt_t;

  // Byte address seen flat or as line and offset
  typedef union packed {
    logic [`SPAD_ADDR_WIDTH-1:0] flat;
    struct packed {
      line_idx_t line;
      byte_ofs_t ofs;
    } part;
  } spad_addr_t;

endpackage

/* source/spad_dma_settings.svh */
`ifndef SPAD_DMA_SETTINGS_SVH
`define SPAD_DMA_SETTINGS_SVH

// Bits in one scratchpad line, split over two banks by line parity
`define SPAD_DATA_WIDTH 32

// Byte address bits, 1 KB of scratchpad
`define SPAD_ADDR_WIDTH 10

// Accelerators served by the read engine
`define ACCEL_COUNT 4

// Descriptor length in bytes, up to 255
`define LEN_WIDTH 8

// Lines buffered per accelerator
`define FIFO_LINES 2

// Bits per accelerator output beat
`define OUT_WIDTH 8

`endif
